// ==== nes_loader_pkg.sv ====
//--------------------------------------------------
// nes loader package: widths, ines constants,
// state encodings and the decoded header record
//--------------------------------------------------
`default_nettype none

package nes_loader_pkg;

  localparam int ADDR_BITS      = 22;  // psram byte address
  localparam int WORD_ADDR_BITS = 23;  // psram word address pins

  typedef logic [7:0]                byte_t;
  typedef logic [ADDR_BITS-1:0]      addr_t;
  typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

  // ines header layout
  localparam int    HEADER_BYTES    = 16;
  localparam int    HEADER_CNT_BITS = $clog2(HEADER_BYTES);
  localparam byte_t INES_MAGIC_0    = 8'h4E;  // "N"
  localparam byte_t INES_MAGIC_1    = 8'h45;  // "E"
  localparam byte_t INES_MAGIC_2    = 8'h53;  // "S"
  localparam byte_t INES_MAGIC_3    = 8'h1A;  // msdos eof

  // bank sizes as shift amounts
  localparam int PRG_BANK_BITS = 14;  // 16 KiB per prg bank
  localparam int CHR_BANK_BITS = 13;  // 8 KiB per chr bank

  localparam addr_t CHR_BASE = 22'h20_0000;  // chr image starts at 2 MiB

  // chip strobes held this many cycles per access
  localparam int PSRAM_WAIT_CYCLES = 3;
  localparam int WAIT_CNT_BITS     = $clog2(PSRAM_WAIT_CYCLES);

  // flags word handed to the mapper logic
  typedef struct packed {
    logic [15:0] reserved;     // always zero
    logic        has_chr_ram;  // no chr rom banks
    logic        vertical;     // byte 6 bit 0
    logic [2:0]  chr_size;
    logic [2:0]  prg_size;
    logic [7:0]  mapper;       // {byte7[7:4], byte6[7:4]}
  } mapper_flags_t;

  typedef struct packed {
    byte_t         prg_banks;
    byte_t         chr_banks;
    mapper_flags_t mapper_flags;
  } header_info_t;

  typedef enum logic {hdr_capture, hdr_loaded} header_state_t;

  typedef enum logic [1:0] {wr_idle, wr_prg, wr_chr, wr_done} writer_state_t;

  typedef enum logic {ps_idle, ps_access} psram_state_t;

endpackage

`default_nettype wire

// ==== mem_req_if.sv ====
//--------------------------------------------------
// loader to psram controller write request bus
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

  logic                  write;  // one-cycle request strobe
  nes_loader_pkg::addr_t addr;   // byte address
  nes_loader_pkg::byte_t data;   // byte to store
  logic                  busy;   // access in flight

  // payload side issues requests
  modport writer (
    output write, addr, data,
    input  busy
  );

  // controller side takes them
  modport ctrl (
    input  write, addr, data,
    output busy
  );

endinterface

`default_nettype wire

// ==== ines_header.sv ====
//--------------------------------------------------
// ines header capture, check and flag decode
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ines_header (
  input  logic                         clk,
  input  logic                         reset,
  input  nes_loader_pkg::byte_t        in_data,
  input  logic                         in_strobe,
  output nes_loader_pkg::header_info_t info,
  output logic                         header_ok
);

  nes_loader_pkg::header_state_t         state;
  logic [nes_loader_pkg::HEADER_CNT_BITS-1:0] ctr;  // header byte index
  nes_loader_pkg::byte_t ines [nes_loader_pkg::HEADER_BYTES];
  logic                                  magic_ok;
  logic                                  format_ok;

  // size code grows by one per doubling of the bank count
  function automatic logic [2:0] size_code(input nes_loader_pkg::byte_t banks);
    logic [2:0] code;
    code = 3'd7;
    for (int i = 6; i >= 0; i--) begin
      if (banks <= (8'd1 << i)) code = 3'(i);  // smallest fitting power wins
    end
    return code;
  endfunction

  // bytes 0..6 are already stored when byte 15 arrives
  assign magic_ok = (ines[0] == nes_loader_pkg::INES_MAGIC_0) &&
                    (ines[1] == nes_loader_pkg::INES_MAGIC_1) &&
                    (ines[2] == nes_loader_pkg::INES_MAGIC_2) &&
                    (ines[3] == nes_loader_pkg::INES_MAGIC_3);
  assign format_ok = !ines[6][2] && !ines[6][3];  // no trainer, no four-screen

  // header byte store
  always_ff @(posedge clk) begin
    if (state == nes_loader_pkg::hdr_capture && in_strobe) begin
      ines[ctr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= nes_loader_pkg::hdr_capture;
      ctr       <= '0;
      header_ok <= 1'b0;
    end else begin
      header_ok <= 1'b0;  // pulse only
      if (state == nes_loader_pkg::hdr_capture && in_strobe) begin
        ctr <= ctr + 1'b1;  // wraps to 0 after byte 15
        if (ctr == nes_loader_pkg::HEADER_BYTES - 1) begin
          if (magic_ok && format_ok) begin
            state     <= nes_loader_pkg::hdr_loaded;
            header_ok <= 1'b1;
          end
          // bad header stays in capture and restarts at byte 0
        end
      end
    end
  end

  // decode from stored bytes
  always_comb begin
    info.prg_banks                 = ines[4];
    info.chr_banks                 = ines[5];
    info.mapper_flags.reserved     = '0;
    info.mapper_flags.has_chr_ram  = (ines[5] == 8'd0);
    info.mapper_flags.vertical     = ines[6][0];
    info.mapper_flags.chr_size     = size_code(ines[5]);
    info.mapper_flags.prg_size     = size_code(ines[4]);
    info.mapper_flags.mapper       = {ines[7][7:4], ines[6][7:4]};
  end

endmodule

`default_nettype wire

// ==== payload_writer.sv ====
//--------------------------------------------------
// prg then chr byte writer into psram, raises done
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module payload_writer (
  input  logic                         clk,
  input  logic                         reset,
  input  nes_loader_pkg::byte_t        in_data,
  input  logic                         in_strobe,
  input  logic                         header_ok,
  input  nes_loader_pkg::header_info_t info,
  mem_req_if.writer                    mem,
  output logic                         hold,
  output logic                         done
);

  nes_loader_pkg::writer_state_t state;
  nes_loader_pkg::writer_state_t act_state;  // state after segment switches
  nes_loader_pkg::addr_t         addr;
  nes_loader_pkg::addr_t         act_addr;
  nes_loader_pkg::addr_t         left;       // bytes left in segment
  nes_loader_pkg::addr_t         act_left;
  nes_loader_pkg::addr_t         prg_len;
  nes_loader_pkg::addr_t         chr_len;
  logic                          take;

  assign prg_len = nes_loader_pkg::addr_t'(info.prg_banks) << nes_loader_pkg::PRG_BANK_BITS;
  assign chr_len = nes_loader_pkg::addr_t'(info.chr_banks) << nes_loader_pkg::CHR_BANK_BITS;

  // segment changes resolved in the same cycle so no byte is dropped
  always_comb begin
    act_state = state;
    act_addr  = addr;
    act_left  = left;
    if (state == nes_loader_pkg::wr_idle && header_ok) begin
      act_state = nes_loader_pkg::wr_prg;  // first payload byte may come now
      act_addr  = '0;
      act_left  = prg_len;
    end
    if (act_state == nes_loader_pkg::wr_prg && act_left == '0) begin
      act_state = nes_loader_pkg::wr_chr;
      act_addr  = nes_loader_pkg::CHR_BASE;
      act_left  = chr_len;
    end
    if (act_state == nes_loader_pkg::wr_chr && act_left == '0) begin
      act_state = nes_loader_pkg::wr_done;  // chr ram image ends after prg
    end
  end

  // source honours hold, so busy is low here
  assign take = in_strobe &&
                (act_state == nes_loader_pkg::wr_prg || act_state == nes_loader_pkg::wr_chr);

  assign mem.write = take;
  assign mem.addr  = act_addr;
  assign mem.data  = in_data;  // byte goes straight through

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= nes_loader_pkg::wr_idle;
      addr  <= '0;
      left  <= '0;
      done  <= 1'b0;
    end else begin
      state <= act_state;
      addr  <= take ? act_addr + 1'b1 : act_addr;  // count up per byte
      left  <= take ? act_left - 1'b1 : act_left;
      done  <= (act_state == nes_loader_pkg::wr_done);  // one edge after last write
    end
  end

  assign hold = mem.busy | done;

endmodule

`default_nettype wire

// ==== psram_controller.sv ====
//--------------------------------------------------
// async psram byte access, loader write or host read
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psram_controller (
  input  logic                       clk,
  input  logic                       reset,
  mem_req_if.ctrl                    mem,
  input  logic                       host_read,
  input  nes_loader_pkg::addr_t      host_addr,
  output nes_loader_pkg::byte_t      host_data,
  output logic                       mem_oe,   // active low
  output logic                       mem_wr,   // active low
  output logic                       mem_adv,
  output logic                       mem_clk,
  output logic                       ram_cs,   // active low
  output logic                       ram_cre,
  output logic                       ram_ub,   // upper lane, active low
  output logic                       ram_lb,   // lower lane, active low
  output nes_loader_pkg::word_addr_t mem_adr,
  inout  wire [15:0]                 mem_db
);

  nes_loader_pkg::psram_state_t            state;
  logic [nes_loader_pkg::WAIT_CNT_BITS-1:0] cnt;  // wait cycles spent
  logic                                    last;
  logic                                    start;
  nes_loader_pkg::addr_t                   req_addr;
  nes_loader_pkg::byte_t                   wdata;

  // async mode only
  assign mem_adv = 1'b0;
  assign mem_clk = 1'b0;
  assign ram_cre = 1'b0;

  // write data on both lanes, released for reads
  assign mem_db = mem_oe ? {wdata, wdata} : 16'bz;

  assign last     = (state == nes_loader_pkg::ps_access) &&
                    (cnt == nes_loader_pkg::PSRAM_WAIT_CYCLES - 1);
  assign start    = (state == nes_loader_pkg::ps_idle || last) && (mem.write || host_read);
  assign req_addr = mem.write ? mem.addr : host_addr;  // loader wins

  // control strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= nes_loader_pkg::ps_idle;
      cnt      <= '0;
      mem.busy <= 1'b0;
      mem_oe   <= 1'b1;
      mem_wr   <= 1'b1;
      ram_cs   <= 1'b1;
      ram_ub   <= 1'b1;
      ram_lb   <= 1'b1;
    end else begin
      if (state == nes_loader_pkg::ps_access) cnt <= cnt + 1'b1;
      if (start) begin
        state    <= nes_loader_pkg::ps_access;
        cnt      <= '0;
        mem.busy <= 1'b1;
        ram_cs   <= 1'b0;
        mem_wr   <= !mem.write;
        mem_oe   <= mem.write;      // oe low only for reads
        ram_ub   <= req_addr[0];    // even byte -> upper lane
        ram_lb   <= !req_addr[0];   // odd byte -> lower lane
      end else if (state == nes_loader_pkg::ps_idle || last) begin
        state    <= nes_loader_pkg::ps_idle;  // release the chip
        mem.busy <= 1'b0;
        mem_oe   <= 1'b1;
        mem_wr   <= 1'b1;
        ram_cs   <= 1'b1;
        ram_ub   <= 1'b1;
        ram_lb   <= 1'b1;
      end
    end
  end

  // address, write data and read result
  always_ff @(posedge clk) begin
    if (last && !mem_oe) begin
      host_data <= ram_ub ? mem_db[7:0] : mem_db[15:8];  // pick the enabled lane
    end
    if (start) begin
      mem_adr <= nes_loader_pkg::word_addr_t'(req_addr[nes_loader_pkg::ADDR_BITS-1:1]);
      wdata   <= mem.data;
    end
  end

endmodule

`default_nettype wire

// ==== nes_image_loader.sv ====
//--------------------------------------------------
// nes image loader top: header, writer, psram ctrl
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nes_image_loader (
  input  logic                          clk,
  input  logic                          reset,
  input  nes_loader_pkg::byte_t         in_data,
  input  logic                          in_strobe,
  input  logic                          host_read,
  input  nes_loader_pkg::addr_t         host_addr,
  output logic                          hold,
  output logic                          done,
  output nes_loader_pkg::mapper_flags_t mapper_flags,
  output nes_loader_pkg::byte_t         host_data,
  output logic                          mem_busy,
  output logic                          mem_oe,
  output logic                          mem_wr,
  output logic                          mem_adv,
  output logic                          mem_clk,
  output logic                          ram_cs,
  output logic                          ram_cre,
  output logic                          ram_ub,
  output logic                          ram_lb,
  output nes_loader_pkg::word_addr_t    mem_adr,
  inout  wire [15:0]                    mem_db
);

  nes_loader_pkg::header_info_t info;
  logic                         header_ok;

  mem_req_if mem_bus ();  // writer -> controller

  ines_header i_ines_header (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_strobe (in_strobe),
    .info      (info),
    .header_ok (header_ok)
  );

  payload_writer i_payload_writer (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_strobe (in_strobe),
    .header_ok (header_ok),
    .info      (info),
    .mem       (mem_bus.writer),
    .hold      (hold),
    .done      (done)
  );

  psram_controller i_psram_controller (
    .clk       (clk),
    .reset     (reset),
    .mem       (mem_bus.ctrl),
    .host_read (host_read),
    .host_addr (host_addr),
    .host_data (host_data),
    .mem_oe    (mem_oe),
    .mem_wr    (mem_wr),
    .mem_adv   (mem_adv),
    .mem_clk   (mem_clk),
    .ram_cs    (ram_cs),
    .ram_cre   (ram_cre),
    .ram_ub    (ram_ub),
    .ram_lb    (ram_lb),
    .mem_adr   (mem_adr),
    .mem_db    (mem_db)
  );

  assign mapper_flags = info.mapper_flags;
  assign mem_busy     = mem_bus.busy;  // controller busy level

endmodule

`default_nettype wire

// ==== tb_psram_model.sv ====
//--------------------------------------------------
// behavioral async psram, sparse 16-bit word store
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_psram_model (
  input  logic                       mem_oe,   // active low
  input  logic                       mem_wr,   // active low
  input  logic                       ram_cs,   // active low
  input  logic                       ram_ub,
  input  logic                       ram_lb,
  input  nes_loader_pkg::word_addr_t mem_adr,
  inout  wire [15:0]                 mem_db
);

  logic [15:0] store [int unsigned];  // keyed by word address
  logic [15:0] rd_word;
  int          write_count = 0;
  int          chr_writes  = 0;       // writes at or above the chr base

  // unwritten words read back a pattern of the full address
  function automatic logic [15:0] lookup(input nes_loader_pkg::word_addr_t a);
    if (store.exists(32'(a))) return store[32'(a)];
    return 16'(a) ^ 16'(a >> 16) ^ 16'hA55A;
  endfunction

  task automatic clear();
    store.delete();
    write_count = 0;
    chr_writes  = 0;
  endtask

  always begin : write_port
    logic [15:0] word;
    @(negedge mem_wr);
    #1;  // strobes, address and data all move on one edge
    if (!ram_cs) begin
      word = lookup(mem_adr);
      if (!ram_ub) word[15:8] = mem_db[15:8];  // upper lane, even byte
      if (!ram_lb) word[7:0]  = mem_db[7:0];
      store[32'(mem_adr)] = word;
      write_count++;
      if (mem_adr >= (nes_loader_pkg::CHR_BASE >> 1)) chr_writes++;
    end
  end

  always begin : read_port
    @(negedge mem_oe or mem_adr);
    #1;
    rd_word = lookup(mem_adr);
  end

  assign mem_db = mem_oe ? 16'bz : rd_word;  // chip drives only while oe low

endmodule

`default_nettype wire

// ==== tb_nes_image_loader.sv ====
//--------------------------------------------------
// testbench for the nes image loader and psram path
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_nes_image_loader;

  logic                          clk = 1'b0;
  logic                          reset, in_strobe, host_read;
  logic                          hold, done, mem_busy, mem_oe, mem_wr, mem_adv, mem_clk;
  logic                          ram_cs, ram_cre, ram_ub, ram_lb;
  nes_loader_pkg::byte_t         in_data, host_data;
  nes_loader_pkg::addr_t         host_addr;
  nes_loader_pkg::mapper_flags_t mapper_flags;
  nes_loader_pkg::word_addr_t    mem_adr;
  wire [15:0]                    mem_db;
  logic [16:0]                   lfsr;          // taps 17 and 14
  nes_loader_pkg::byte_t         payload [$];   // expected image in load order
  int                            errors, checks;

  always #20 clk = ~clk;  // 40 ns period

  nes_image_loader i_nes_image_loader (.*);
  tb_psram_model   i_psram_model (.*);

  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // 0 up to one bank, one more per doubling, saturates at 7
  function automatic logic [2:0] bank_code(input int banks);
    logic [2:0] code;
    int         lim;
    code = 3'd0;
    lim  = 1;
    while (banks > lim && code != 3'd7) begin
      lim  = lim * 2;
      code = code + 3'd1;
    end
    return code;
  endfunction

  function automatic nes_loader_pkg::mapper_flags_t expected_flags(
    input nes_loader_pkg::byte_t prg, chr, b6, b7);
    nes_loader_pkg::mapper_flags_t f;
    f             = '0;
    f.has_chr_ram = (chr == 8'd0);
    f.vertical    = b6[0];
    f.chr_size    = bank_code(int'(chr));
    f.prg_size    = bank_code(int'(prg));
    f.mapper      = {b7[7:4], b6[7:4]};  // high nibble from byte 7
    return f;
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;  // drive and sample away from the edge
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: no %s within the cycle limit", what);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_byte(input nes_loader_pkg::byte_t got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input nes_loader_pkg::mapper_flags_t got, exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic rand_byte(output nes_loader_pkg::byte_t b);
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[16]};  // one bit per step
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic send_byte(input nes_loader_pkg::byte_t b);
    int n;
    n = 0;
    while (hold) begin
      if (n++ == 20) timeout_abort("hold release");
      tick();
    end
    in_data   = b;
    in_strobe = 1'b1;
    tick();  // consumed on this edge
    in_strobe = 1'b0;
  endtask

  task automatic send_header(input nes_loader_pkg::byte_t magic3, prg, chr, b6, b7);
    nes_loader_pkg::byte_t hdr [16];
    hdr = '{8'h4E, 8'h45, 8'h53, magic3, prg, chr, b6, b7, 8'h00, 8'h00, 8'h00, 8'h00,
            8'h00, 8'h00, 8'h00, 8'h00};  // "NES" then the rest
    foreach (hdr[i]) send_byte(hdr[i]);
  endtask

  task automatic load_image(input nes_loader_pkg::byte_t prg, chr, b6, b7);
    nes_loader_pkg::byte_t b;
    int                    len;
    int                    n;
    len = int'(prg) * 16384 + int'(chr) * 8192;
    payload.delete();
    send_header(8'h1A, prg, chr, b6, b7);
    for (int i = 0; i < len; i++) begin
      rand_byte(b);
      payload.push_back(b);
      send_byte(b);
    end
    check_level(done, 1'b0, "done on the final write edge");
    n = 0;
    while (!done) begin
      if (n++ == 10) timeout_abort("done after the last payload byte");
      tick();
    end
    check_flags(mapper_flags, expected_flags(prg, chr, b6, b7), "mapper flags");
  endtask

  task automatic read_back(input nes_loader_pkg::addr_t addr, input nes_loader_pkg::byte_t exp);
    int n;
    n = 0;
    while (mem_busy) begin
      if (n++ == 10) timeout_abort("idle controller before a host read");
      tick();
    end
    host_addr = addr;
    host_read = 1'b1;
    tick();
    host_read = 1'b0;
    n = 0;
    while (mem_busy) begin  // busy rose on the accepting edge
      if (n == 10) timeout_abort("end of a host read");
      n++;
      tick();
    end
    check_count(n, 3, "busy cycles per read");
    check_byte(host_data, exp, $sformatf("byte at %06h", addr));
  endtask

  // even and odd offsets near both ends of prg, then chr
  task automatic check_samples(input int prg_len);
    int offs [6] = '{0, 1, 2, 3, 'h2345, 'h3FFF};
    foreach (offs[k]) begin
      read_back(nes_loader_pkg::addr_t'(offs[k]), payload[offs[k]]);
      read_back(nes_loader_pkg::addr_t'(prg_len - 1 - offs[k]), payload[prg_len - 1 - offs[k]]);
      if (payload.size() > prg_len) begin
        read_back(nes_loader_pkg::CHR_BASE + nes_loader_pkg::addr_t'(offs[k] & 'h1FFF),
                  payload[prg_len + (offs[k] & 'h1FFF)]);
      end
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) tick();
    reset = 1'b0;
    i_psram_model.clear();
  endtask

  task automatic test_reset_state();
    apply_reset();
    check_level(hold | done | mem_busy, 1'b0, "hold, done or busy after reset");
    check_level(mem_oe & mem_wr & ram_cs & ram_ub & ram_lb, 1'b1, "chip strobes after reset");
    check_level(mem_adv | mem_clk | ram_cre, 1'b0, "tied psram pins");
  endtask

  task automatic test_full_load();
    apply_reset();
    load_image(8'd1, 8'd1, 8'h41, 8'h00);  // mapper 4, vertical
    check_samples(16384);
  endtask

  // runs on the image left by the full load
  task automatic test_lanes_and_read_port();
    read_back(22'h00_0100, payload[256]);  // both lanes of one word
    read_back(22'h00_0101, payload[257]);
    read_back(nes_loader_pkg::CHR_BASE + 22'h20, payload[16384 + 32]);
    read_back(nes_loader_pkg::CHR_BASE + 22'h21, payload[16384 + 33]);
    repeat (4) tick();
    check_level(hold, 1'b1, "hold once done");
  endtask

  task automatic test_chr_ram();
    apply_reset();
    load_image(8'd2, 8'd0, 8'h10, 8'h20);  // mapper 0x21, horizontal
    check_count(i_psram_model.chr_writes, 0, "writes at the chr base");
    check_count(i_psram_model.write_count, 32768, "payload writes");
    check_samples(32768);
  endtask

  task automatic test_resync();
    apply_reset();
    send_header(8'h1B, 8'd2, 8'd2, 8'h41, 8'h00);  // bad magic
    send_header(8'h1A, 8'd2, 8'd2, 8'h44, 8'h00);  // trainer bit
    send_header(8'h1A, 8'd2, 8'd2, 8'h48, 8'h00);  // four-screen bit
    check_count(i_psram_model.write_count, 0, "writes before a valid header");
    load_image(8'd1, 8'd0, 8'h31, 8'h00);
    check_count(i_psram_model.write_count, 16384, "payload writes");
    check_samples(16384);
  endtask

  initial begin
    reset     = 1'b1;
    in_strobe = 1'b0;
    in_data   = '0;
    host_read = 1'b0;
    host_addr = '0;
    lfsr      = 17'd70480;
    errors    = 0;
    checks    = 0;
    test_reset_state();
    test_full_load();
    test_lanes_and_read_port();
    test_chr_ram();
    test_resync();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== nes_image_loader.f ====
nes_loader_pkg.sv
mem_req_if.sv
ines_header.sv
payload_writer.sv
psram_controller.sv
nes_image_loader.sv
tb_psram_model.sv
tb_nes_image_loader.sv

// ==== Makefile ====
# Verilator build and run of the nes image loader testbench

TOP = tb_nes_image_loader

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
	  -f nes_image_loader.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
